// ==== logic/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

	// register data width.
	localparam int xlen = 32;

	// architectural registers, x0 hardwired to zero.
	localparam int num_regs = 32;

	// reorder buffer entries. tag arithmetic wraps, so keep this a power of two.
	localparam int rob_depth = 8;

	// a register or result value.
	typedef logic [xlen-1:0] xlen_t;

	// architectural register number.
	typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

	// reorder buffer slot, doubles as the rename tag.
	typedef logic [$clog2(rob_depth)-1:0] tag_t;

	// occupancy, 0 up to rob_depth inclusive.
	typedef logic [$clog2(rob_depth):0] count_t;

endpackage

`default_nettype wire

// ==== logic/rob_status_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// per-entry reorder buffer state plus retire and flush events.
interface rob_status_if;
	logic entry_valid [ooo_pkg::rob_depth];
	logic entry_rdy [ooo_pkg::rob_depth]; // result written back.
	ooo_pkg::reg_idx_t entry_rd [ooo_pkg::rob_depth];
	ooo_pkg::xlen_t entry_data [ooo_pkg::rob_depth];
	ooo_pkg::tag_t head; // oldest entry.
	logic commit; // head retires at this edge.
	logic flush;
	ooo_pkg::tag_t flush_tag; // last surviving entry.

	modport rob (
		output entry_valid,
		output entry_rdy,
		output entry_rd,
		output entry_data,
		output head,
		output commit,
		output flush,
		output flush_tag
	);

	modport regfile (
		input entry_valid,
		input entry_rdy,
		input entry_rd,
		input entry_data,
		input head,
		input commit,
		input flush,
		input flush_tag
	);
endinterface

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispatch,
	input wire ooo_pkg::reg_idx_t disp_rd,
	input wire logic wb_valid,
	input wire ooo_pkg::tag_t wb_tag,
	input wire ooo_pkg::xlen_t wb_data,
	input wire logic flush,
	input wire ooo_pkg::tag_t flush_tag,
	output ooo_pkg::tag_t disp_tag,
	output logic rob_full,
	output logic commit_valid,
	output ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::xlen_t commit_data,
	rob_status_if.rob status
);
	logic valid [ooo_pkg::rob_depth];
	logic rdy [ooo_pkg::rob_depth];
	ooo_pkg::reg_idx_t rd [ooo_pkg::rob_depth];
	ooo_pkg::xlen_t data [ooo_pkg::rob_depth];
	logic keep [ooo_pkg::rob_depth]; // entry survives a flush.

	ooo_pkg::tag_t head;
	ooo_pkg::tag_t tail;
	ooo_pkg::count_t count;
	ooo_pkg::count_t count_next;
	ooo_pkg::tag_t span; // distance head to flush_tag.
	logic accept;
	logic wb_hit;

	assign accept = dispatch && !rob_full && !flush;
	assign wb_hit = wb_valid && valid[wb_tag];
	assign span = flush_tag - head;

	assign disp_tag = tail; // next free slot.
	assign rob_full = (count == ooo_pkg::count_t'(ooo_pkg::rob_depth));

	// in-order retire, one per cycle.
	assign commit_valid = valid[head] && rdy[head];
	assign commit_rd = rd[head];
	assign commit_data = data[head];

	// survivors are head through flush_tag, counted with wrap.
	always_comb begin
		ooo_pkg::tag_t off;
		for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
			off = ooo_pkg::tag_t'(i) - head;
			keep[i] = (off <= span);
		end
	end

	always_comb begin
		if (flush) begin
			count_next = ooo_pkg::count_t'(span) + ooo_pkg::count_t'(1);
		end else begin
			count_next = count;
			if (accept)
				count_next = count_next + ooo_pkg::count_t'(1);
		end
		// head retires even when a flush lands in the same cycle.
		if (commit_valid)
			count_next = count_next - ooo_pkg::count_t'(1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
				valid[i] <= 1'b0;
				rdy[i] <= 1'b0;
			end
		end else begin
			count <= count_next;
			if (wb_hit)
				rdy[wb_tag] <= 1'b1;
			if (commit_valid) begin
				valid[head] <= 1'b0;
				rdy[head] <= 1'b0;
				head <= head + ooo_pkg::tag_t'(1);
			end
			if (flush) begin
				tail <= flush_tag + ooo_pkg::tag_t'(1);
				for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
					if (!keep[i]) begin
						valid[i] <= 1'b0;
						rdy[i] <= 1'b0;
					end
				end
			end else if (accept) begin
				valid[tail] <= 1'b1;
				rdy[tail] <= 1'b0;
				tail <= tail + ooo_pkg::tag_t'(1);
			end
		end
	end

	// destination and result payload.
	always_ff @(posedge clk) begin
		if (accept)
			rd[tail] <= disp_rd;
		if (wb_hit)
			data[wb_tag] <= wb_data;
	end

	always_comb begin
		for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
			status.entry_valid[i] = valid[i];
			status.entry_rdy[i] = rdy[i];
			status.entry_rd[i] = rd[i];
			status.entry_data[i] = data[i];
		end
	end

	assign status.head = head;
	assign status.commit = commit_valid;
	assign status.flush = flush;
	assign status.flush_tag = flush_tag;

	occupancy_bound: assert property (@(posedge clk) disable iff (rst)
		count <= ooo_pkg::count_t'(ooo_pkg::rob_depth))
		else $error("reorder buffer holds %0d entries, more than its depth", count);

	wb_live_entry: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> valid[wb_tag])
		else $error("writeback to tag %0d, which holds no instruction", wb_tag);

endmodule

`default_nettype wire

// ==== logic/rename_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_regfile (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispatch,
	input wire logic rob_full,
	input wire ooo_pkg::reg_idx_t disp_rd,
	input wire ooo_pkg::tag_t disp_tag,
	input wire ooo_pkg::reg_idx_t rs1,
	input wire ooo_pkg::reg_idx_t rs2,
	rob_status_if.regfile status,
	output logic rs1_busy,
	output ooo_pkg::xlen_t rs1_val,
	output logic rs2_busy,
	output ooo_pkg::xlen_t rs2_val
);
	ooo_pkg::xlen_t regs [ooo_pkg::num_regs]; // committed values.
	logic busy [ooo_pkg::num_regs];
	ooo_pkg::tag_t tag [ooo_pkg::num_regs]; // youngest pending writer.

	// mapping rebuilt from the entries that survive a flush.
	logic rec_busy [ooo_pkg::num_regs];
	ooo_pkg::tag_t rec_tag [ooo_pkg::num_regs];

	ooo_pkg::reg_idx_t head_rd;
	ooo_pkg::xlen_t head_data;
	logic rename;

	assign head_rd = status.entry_rd[status.head];
	assign head_data = status.entry_data[status.head];

	// flush blocks a dispatch too, handled by the flush branch below.
	assign rename = dispatch && !rob_full && (disp_rd != '0);

	// busy bit on top, value or zero-extended tag below.
	function automatic logic [ooo_pkg::xlen:0] read_port(ooo_pkg::reg_idx_t idx);
		ooo_pkg::tag_t t;
		t = tag[idx];
		if (!busy[idx])
			return {1'b0, regs[idx]};
		if (status.entry_rdy[t])
			return {1'b0, status.entry_data[t]}; // forward from the reorder buffer.
		return {1'b1, ooo_pkg::xlen_t'(t)};
	endfunction

	assign {rs1_busy, rs1_val} = read_port(rs1);
	assign {rs2_busy, rs2_val} = read_port(rs2);

	// walk survivors oldest first, so the last match is the youngest writer.
	// a head that retires this edge no longer counts as pending.
	always_comb begin
		ooo_pkg::tag_t span;
		ooo_pkg::tag_t idx;
		span = status.flush_tag - status.head;
		for (int r = 0; r < ooo_pkg::num_regs; r++) begin
			rec_busy[r] = 1'b0;
			rec_tag[r] = '0;
			for (int k = 0; k < ooo_pkg::rob_depth; k++) begin
				idx = status.head + ooo_pkg::tag_t'(k);
				if (r != 0 && ooo_pkg::tag_t'(k) <= span
						&& !(k == 0 && status.commit)
						&& status.entry_valid[idx]
						&& status.entry_rd[idx] == ooo_pkg::reg_idx_t'(r)) begin
					rec_busy[r] = 1'b1;
					rec_tag[r] = idx;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < ooo_pkg::num_regs; r++) begin
				regs[r] <= '0;
				busy[r] <= 1'b0;
				tag[r] <= '0;
			end
		end else begin
			if (status.commit && head_rd != '0)
				regs[head_rd] <= head_data;
			if (status.flush) begin
				for (int r = 0; r < ooo_pkg::num_regs; r++) begin
					busy[r] <= rec_busy[r];
					tag[r] <= rec_tag[r];
				end
			end else begin
				// a younger writer keeps the register renamed.
				if (status.commit && head_rd != '0 && tag[head_rd] == status.head)
					busy[head_rd] <= 1'b0;
				if (rename) begin
					busy[disp_rd] <= 1'b1; // overrides a same-cycle commit.
					tag[disp_rd] <= disp_tag;
				end
			end
		end
	end

	x0_not_renamed: assert property (@(posedge clk) disable iff (rst) !busy[0])
		else $error("register 0 marked busy with tag %0d", tag[0]);

endmodule

`default_nettype wire

// ==== logic/rename_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispatch,
	input wire ooo_pkg::reg_idx_t disp_rd,
	input wire ooo_pkg::reg_idx_t rs1,
	input wire ooo_pkg::reg_idx_t rs2,
	input wire logic wb_valid,
	input wire ooo_pkg::tag_t wb_tag,
	input wire ooo_pkg::xlen_t wb_data,
	input wire logic flush,
	input wire ooo_pkg::tag_t flush_tag,
	output ooo_pkg::tag_t disp_tag,
	output logic rob_full,
	output logic rs1_busy,
	output ooo_pkg::xlen_t rs1_val,
	output logic rs2_busy,
	output ooo_pkg::xlen_t rs2_val,
	output logic commit_valid,
	output ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::xlen_t commit_data
);
	rob_status_if status ();

	reorder_buffer rob (
		.clk (clk),
		.rst (rst),
		.dispatch (dispatch),
		.disp_rd (disp_rd),
		.wb_valid (wb_valid),
		.wb_tag (wb_tag),
		.wb_data (wb_data),
		.flush (flush),
		.flush_tag (flush_tag),
		.disp_tag (disp_tag),
		.rob_full (rob_full),
		.commit_valid (commit_valid),
		.commit_rd (commit_rd),
		.commit_data (commit_data),
		.status (status.rob)
	);

	// tag and full flag come back from the buffer for renaming.
	rename_regfile rf (
		.clk (clk),
		.rst (rst),
		.dispatch (dispatch),
		.rob_full (rob_full),
		.disp_rd (disp_rd),
		.disp_tag (disp_tag),
		.rs1 (rs1),
		.rs2 (rs2),
		.status (status.regfile),
		.rs1_busy (rs1_busy),
		.rs1_val (rs1_val),
		.rs2_busy (rs2_busy),
		.rs2_val (rs2_val)
	);

endmodule

`default_nettype wire

// ==== dv/rename_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// compares the core's ports with the model's expectations every cycle.
module rename_checker (
	input wire logic clk,
	input wire logic rst,
	input wire logic done,
	input wire ooo_pkg::tag_t disp_tag,
	input wire logic rob_full,
	input wire logic rs1_busy,
	input wire ooo_pkg::xlen_t rs1_val,
	input wire logic rs2_busy,
	input wire ooo_pkg::xlen_t rs2_val,
	input wire logic commit_valid,
	input wire ooo_pkg::reg_idx_t commit_rd,
	input wire ooo_pkg::xlen_t commit_data,
	input wire ooo_pkg::tag_t exp_disp_tag,
	input wire logic exp_rob_full,
	input wire logic exp_rs1_busy,
	input wire ooo_pkg::xlen_t exp_rs1_val,
	input wire logic exp_rs2_busy,
	input wire ooo_pkg::xlen_t exp_rs2_val,
	input wire logic exp_commit_valid,
	input wire ooo_pkg::reg_idx_t exp_commit_rd,
	input wire ooo_pkg::xlen_t exp_commit_data,
	output int errors
);
	int checks;

	initial begin
		errors = 0;
		checks = 0;
	end

	task automatic compare(string name, logic [32:0] actual, logic [32:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	// falling edge, well clear of the drive and the model update.
	always @(negedge clk) begin
		if (!rst) begin
			compare("disp_tag", 33'(disp_tag), 33'(exp_disp_tag));
			compare("rob_full", 33'(rob_full), 33'(exp_rob_full));
			compare("commit_valid", 33'(commit_valid), 33'(exp_commit_valid));
			if (exp_commit_valid) begin
				compare("commit_rd", 33'(commit_rd), 33'(exp_commit_rd));
				compare("commit_data", 33'(commit_data), 33'(exp_commit_data));
			end
			compare("rs1_busy", 33'(rs1_busy), 33'(exp_rs1_busy));
			compare("rs1_val", 33'(rs1_val), 33'(exp_rs1_val));
			compare("rs2_busy", 33'(rs2_busy), 33'(exp_rs2_busy));
			compare("rs2_val", 33'(rs2_val), 33'(exp_rs2_val));
		end
	end

	always @(posedge done)
		$display("checks %0d, errors %0d", checks, errors);

endmodule

`default_nettype wire

// ==== dv/rename_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_tb;
	logic clk;
	logic rst;
	logic dispatch;
	ooo_pkg::reg_idx_t disp_rd;
	ooo_pkg::reg_idx_t rs1;
	ooo_pkg::reg_idx_t rs2;
	logic wb_valid;
	ooo_pkg::tag_t wb_tag;
	ooo_pkg::xlen_t wb_data;
	logic flush;
	ooo_pkg::tag_t flush_tag;
	ooo_pkg::tag_t disp_tag;
	logic rob_full;
	logic rs1_busy;
	ooo_pkg::xlen_t rs1_val;
	logic rs2_busy;
	ooo_pkg::xlen_t rs2_val;
	logic commit_valid;
	ooo_pkg::reg_idx_t commit_rd;
	ooo_pkg::xlen_t commit_data;

	// model of the buffer and the register file.
	logic m_valid [ooo_pkg::rob_depth];
	logic m_rdy [ooo_pkg::rob_depth];
	ooo_pkg::reg_idx_t m_rd [ooo_pkg::rob_depth];
	ooo_pkg::xlen_t m_data [ooo_pkg::rob_depth];
	ooo_pkg::tag_t m_head;
	ooo_pkg::tag_t m_tail;
	int m_count;
	ooo_pkg::xlen_t m_regs [ooo_pkg::num_regs];
	logic m_busy [ooo_pkg::num_regs];
	ooo_pkg::tag_t m_tag [ooo_pkg::num_regs];

	ooo_pkg::tag_t exp_disp_tag;
	logic exp_rob_full;
	logic exp_rs1_busy;
	ooo_pkg::xlen_t exp_rs1_val;
	logic exp_rs2_busy;
	ooo_pkg::xlen_t exp_rs2_val;
	logic exp_commit_valid;
	ooo_pkg::reg_idx_t exp_commit_rd;
	ooo_pkg::xlen_t exp_commit_data;
	int errors;
	int stalls;
	logic done;

	rename_core uut (.*);
	rename_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// busy flag on top of the committed, forwarded or tag value.
	function automatic logic [32:0] expected_read(ooo_pkg::reg_idx_t r);
		if (!m_busy[r])
			return {1'b0, m_regs[r]};
		if (m_rdy[m_tag[r]])
			return {1'b0, m_data[m_tag[r]]};
		return {1'b1, ooo_pkg::xlen_t'(m_tag[r])};
	endfunction

	always @(posedge clk) begin
		logic com;
		logic full;
		ooo_pkg::tag_t h0;
		ooo_pkg::tag_t span;
		ooo_pkg::tag_t t;
		if (rst) begin
			m_head = '0;
			m_tail = '0;
			m_count = 0;
			for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
				m_valid[i] = 1'b0;
				m_rdy[i] = 1'b0;
			end
			for (int r = 0; r < ooo_pkg::num_regs; r++) begin
				m_regs[r] = '0;
				m_busy[r] = 1'b0;
				m_tag[r] = '0;
			end
		end else begin
			h0 = m_head;
			com = m_valid[h0] && m_rdy[h0];
			full = (m_count == ooo_pkg::rob_depth);
			span = flush_tag - h0;
			if (wb_valid && m_valid[wb_tag]) begin
				m_rdy[wb_tag] = 1'b1;
				m_data[wb_tag] = wb_data;
			end
			if (com) begin
				if (m_rd[h0] != '0) begin
					m_regs[m_rd[h0]] = m_data[h0];
					if (m_tag[m_rd[h0]] == h0)
						m_busy[m_rd[h0]] = 1'b0; // no younger writer.
				end
				m_valid[h0] = 1'b0;
				m_rdy[h0] = 1'b0;
				m_head = h0 + ooo_pkg::tag_t'(1);
				m_count--;
			end
			if (flush) begin
				for (int r = 0; r < ooo_pkg::num_regs; r++)
					m_busy[r] = 1'b0;
				// walking oldest first leaves the youngest survivor last.
				for (int k = 0; k < ooo_pkg::rob_depth; k++) begin
					t = h0 + ooo_pkg::tag_t'(k);
					if (ooo_pkg::tag_t'(k) > span) begin
						m_valid[t] = 1'b0;
						m_rdy[t] = 1'b0;
					end else if (m_valid[t] && m_rd[t] != '0) begin
						m_busy[m_rd[t]] = 1'b1;
						m_tag[m_rd[t]] = t;
					end
				end
				m_tail = flush_tag + ooo_pkg::tag_t'(1);
				m_count = int'(span) + 1 - (com ? 1 : 0);
			end else if (dispatch && !full) begin
				m_valid[m_tail] = 1'b1;
				m_rdy[m_tail] = 1'b0;
				m_rd[m_tail] = disp_rd;
				if (disp_rd != '0) begin
					m_busy[disp_rd] = 1'b1;
					m_tag[disp_rd] = m_tail;
				end
				m_tail = m_tail + ooo_pkg::tag_t'(1);
				m_count++;
			end
		end
	end

	// expectations settle mid-cycle after the model and the input drive.
	always @(posedge clk) begin
		#10;
		{exp_rs1_busy, exp_rs1_val} = expected_read(rs1);
		{exp_rs2_busy, exp_rs2_val} = expected_read(rs2);
		exp_disp_tag = m_tail;
		exp_rob_full = (m_count == ooo_pkg::rob_depth);
		exp_commit_valid = m_valid[m_head] && m_rdy[m_head];
		exp_commit_rd = m_rd[m_head];
		exp_commit_data = m_data[m_head];
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
		dispatch = 1'b0;
		wb_valid = 1'b0;
		flush = 1'b0;
	endtask

	task automatic pick_pending(output ooo_pkg::tag_t t, output logic found);
		ooo_pkg::tag_t pend [$];
		for (int i = 0; i < ooo_pkg::rob_depth; i++)
			if (m_valid[i] && !m_rdy[i])
				pend.push_back(ooo_pkg::tag_t'(i));
		found = (pend.size() > 0);
		t = found ? pend[$urandom % pend.size()] : '0;
	endtask

	task automatic write_back_one();
		ooo_pkg::tag_t t;
		logic found;
		pick_pending(t, found);
		if (found) begin
			wb_valid = 1'b1;
			wb_tag = t;
			wb_data = $urandom;
		end
	endtask

	task automatic random_cycle();
		next_cycle();
		rs1 = ooo_pkg::reg_idx_t'($urandom % 8);
		rs2 = ooo_pkg::reg_idx_t'($urandom % 8);
		if ($urandom % 16 == 0 && m_count > 0) begin
			flush = 1'b1;
			flush_tag = m_head + ooo_pkg::tag_t'($urandom % m_count);
		end else begin
			dispatch = ($urandom % 2 == 0);
			disp_rd = ooo_pkg::reg_idx_t'($urandom % 8); // few registers give many overlaps.
			if ($urandom % 2 == 0)
				write_back_one();
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (m_count > 0 && n < 64) begin
			next_cycle();
			rs1 = ooo_pkg::reg_idx_t'($urandom % 8);
			write_back_one();
			n++;
		end
		if (m_count > 0) begin
			stalls++;
			$display("stall: reorder buffer still holds %0d entries after 64 cycles", m_count);
		end
	endtask

	task automatic fill_run();
		int n;
		n = 0;
		while (m_count < ooo_pkg::rob_depth && n < 32) begin
			next_cycle();
			dispatch = 1'b1;
			disp_rd = ooo_pkg::reg_idx_t'($urandom % 8);
			n++;
		end
		if (m_count < ooo_pkg::rob_depth) begin
			stalls++;
			$display("stall: reorder buffer never filled within 32 cycles");
		end else begin
			repeat (4) begin
				next_cycle();
				dispatch = 1'b1; // held while full.
				disp_rd = ooo_pkg::reg_idx_t'($urandom % 8);
				rs1 = disp_rd;
			end
		end
	endtask

	task automatic sweep_reads();
		for (int r = 0; r < ooo_pkg::num_regs; r += 2) begin
			next_cycle();
			rs1 = ooo_pkg::reg_idx_t'(r);
			rs2 = ooo_pkg::reg_idx_t'(r + 1);
		end
	endtask

	initial begin
		void'($urandom(32'h0d5564a7));
		rst = 1'b1;
		dispatch = 1'b0;
		disp_rd = '0;
		rs1 = '0;
		rs2 = '0;
		wb_valid = 1'b0;
		wb_tag = '0;
		wb_data = '0;
		flush = 1'b0;
		flush_tag = '0;
		stalls = 0;
		done = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		sweep_reads();
		for (int p = 0; p < 4 && stalls == 0; p++) begin
			repeat (100) random_cycle();
			drain();
		end
		if (stalls == 0)
			fill_run();
		if (stalls == 0)
			drain();
		if (stalls == 0)
			sweep_reads();
		next_cycle();
		done = 1'b1;
		#1;
		if (errors == 0 && stalls == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
logic/ooo_pkg.sv
logic/rob_status_if.sv
logic/reorder_buffer.sv
logic/rename_regfile.sv
logic/rename_core.sv
dv/rename_checker.sv
dv/rename_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the rename core testbench with Verilator, runs it and scans the log.
rm -f sim.log
verilator --binary --timing --assert --top-module rename_tb -f all.f -o rename_sim \
	&& ./obj_dir/rename_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
